/* hw/mbcPkg.sv */
// Memory bus control definitions
`default_nettype none

package mbcPkg;

  // Words in one memory block.
  localparam int WordCount = 4;

  // Clock cycles in one bus slot.
  localparam int PhaseLength = 2;

  // Cycles from a sampled memory data valid to core data valid.
  localparam int DataValidDelay = 2;

  // One bit per word of the block, set when the word is requested.
  typedef logic [WordCount-1:0] wordMaskT;

  // Word address inside the block.
  typedef logic [1:0] wordAdrT;

  // Enough bits to count every word of a block.
  typedef logic [$clog2(WordCount+1)-1:0] ackCountT;

  // States of the memory start machine.
  typedef enum logic [1:0] {
    IDLE,
    WAIT_SLOT,
    STARTED,
    CLOSING
  } startStateT;

endpackage

`default_nettype wire

/* hw/memReqIf.sv */
// Held memory request bus
`default_nettype none

interface memReqIf;

  mbcPkg::wordMaskT rqMask;
  logic rdRq;
  logic wrRq;
  mbcPkg::wordAdrT startAdr;
  logic rqHold;
  // One per acknowledged word.
  logic ackPulse;
  logic lastAckn;

  modport hold(
    output rqMask, rdRq, wrRq, startAdr, rqHold, lastAckn,
    input  ackPulse
  );

  modport start(
    input  rqHold, rdRq, lastAckn,
    output ackPulse
  );

  modport core(
    input  rqMask, startAdr, rdRq
  );

endinterface

`default_nettype wire

/* hw/phaseGen.sv */
// Memory bus slot timing
`default_nettype none

module phaseGen (
  input  logic clk,
  input  logic rst,
  output logic aChangeComing,
  output logic bChangeComing,
  output logic phaseA
);

  logic [$clog2(mbcPkg::PhaseLength)-1:0] cycleCnt;
  logic slotEnd;

  // The last cycle of a slot announces the slot that follows it.
  assign slotEnd = (int'(cycleCnt) == mbcPkg::PhaseLength - 1);
  assign aChangeComing = slotEnd && !phaseA;
  assign bChangeComing = slotEnd && phaseA;

  always_ff @(posedge clk) begin
    if (rst) begin
      cycleCnt <= '0;
      phaseA <= 1'b0;
    end else begin
      if (slotEnd) begin
        cycleCnt <= '0;
        phaseA <= !phaseA;
      end else begin
        cycleCnt <= cycleCnt + 1'b1;
      end
    end
  end

  pulsesExclusive: assert property (
    @(posedge clk) disable iff (rst)
    !(aChangeComing && bChangeComing)
  ) else $error("A and B change pulses high together");

endmodule

`default_nettype wire

/* hw/requestHold.sv */
// Memory request hold and address parity
`default_nettype none

module requestHold (
  input  logic clk,
  input  logic rst,
  input  logic reqValid,
  output logic reqReady,
  input  mbcPkg::wordMaskT reqWords,
  input  logic reqRead,
  input  logic reqWrite,
  input  mbcPkg::wordAdrT reqAdr,
  input  logic reqAdrPar,
  input  logic forceBadPar,
  input  logic startDone,
  output logic memAdrPar,
  memReqIf.hold rq
);

  mbcPkg::ackCountT pending;
  logic adrParHold;
  logic badParHold;
  logic transfer;

  function automatic mbcPkg::ackCountT countWords(input mbcPkg::wordMaskT mask);
    mbcPkg::ackCountT total;
    total = '0;
    for (int i = 0; i < mbcPkg::WordCount; i++) begin
      total = total + mbcPkg::ackCountT'(mask[i]);
    end
    return total;
  endfunction

  assign reqReady = !rq.rqHold;
  assign transfer = reqValid && reqReady;

  // The final acknowledge is the one that meets a single pending word.
  assign rq.lastAckn = rq.ackPulse && (pending == mbcPkg::ackCountT'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      rq.rqHold <= 1'b0;
      pending <= '0;
    end else begin
      if (transfer) begin
        rq.rqHold <= 1'b1;
        pending <= countWords(reqWords);
      end else begin
        if (startDone) begin
          rq.rqHold <= 1'b0;
        end
        if (rq.ackPulse && pending != '0) begin
          pending <= pending - mbcPkg::ackCountT'(1);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (transfer) begin
      rq.rqMask <= reqWords;
      rq.rdRq <= reqRead;
      rq.wrRq <= reqWrite;
      rq.startAdr <= reqAdr;
      adrParHold <= reqAdrPar;
      badParHold <= forceBadPar;
    end
  end

  // Parity covers the request fields as well as the address, so a forced
  // bad parity test flips the whole sum.
  assign memAdrPar = adrParHold ^ rq.rdRq ^ rq.wrRq ^ (^rq.rqMask) ^
                     (^rq.startAdr) ^ badParHold;

  heldRequestOneKind: assert property (
    @(posedge clk) disable iff (rst)
    rq.rqHold |-> !(rq.rdRq && rq.wrRq)
  ) else $error("Held request is both read and write");

endmodule

`default_nettype wire

/* hw/memStartCtl.sv */
// Memory start control
`default_nettype none

module memStartCtl (
  input  logic clk,
  input  logic rst,
  input  logic aChangeComing,
  input  logic bChangeComing,
  input  logic memAcknA,
  input  logic memAcknB,
  input  logic nxmAckn,
  output logic memStartA,
  output logic memStartB,
  output logic startDone,
  memReqIf.start rq
);

  mbcPkg::startStateT state;
  logic slotPulse;
  logic startAny;

  assign slotPulse = aChangeComing || bChangeComing;
  assign startAny = memStartA || memStartB;

  // An acknowledge is taken once per slot, at the change pulse of its own slot.
  // A missing memory answers in either slot.
  assign rq.ackPulse = (state == mbcPkg::STARTED) &&
                       (((memAcknA || nxmAckn) && aChangeComing) ||
                        ((memAcknB || nxmAckn) && bChangeComing));

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= mbcPkg::IDLE;
      memStartA <= 1'b0;
      memStartB <= 1'b0;
      startDone <= 1'b0;
    end else begin
      startDone <= 1'b0;
      case (state)
        mbcPkg::IDLE, mbcPkg::WAIT_SLOT: begin
          if (rq.rqHold) begin
            // The first slot to come takes the request.
            if (slotPulse) begin
              memStartA <= aChangeComing;
              memStartB <= bChangeComing;
              state <= mbcPkg::STARTED;
            end else begin
              state <= mbcPkg::WAIT_SLOT;
            end
          end
        end
        mbcPkg::STARTED: begin
          if (rq.lastAckn) begin
            memStartA <= 1'b0;
            memStartB <= 1'b0;
            startDone <= 1'b1;
            state <= mbcPkg::CLOSING;
          end
        end
        mbcPkg::CLOSING: begin
          // The hold is still up here and must not start again.
          state <= mbcPkg::IDLE;
        end
        default: begin
          state <= mbcPkg::IDLE;
        end
      endcase
    end
  end

  startsExclusive: assert property (
    @(posedge clk) disable iff (rst)
    !(memStartA && memStartB)
  ) else $error("Both memory starts high");

  readFlagStable: assert property (
    @(posedge clk) disable iff (rst)
    startAny && $past(startAny) |-> $stable(rq.rdRq)
  ) else $error("Read flag changed during a memory start");

endmodule

`default_nettype wire

/* hw/coreReadSeq.sv */
// Core read sequencing
`default_nettype none

module coreReadSeq (
  input  logic clk,
  input  logic rst,
  input  logic aChangeComing,
  input  logic bChangeComing,
  input  logic memDataValidA,
  input  logic memDataValidB,
  input  logic nxmDataValid,
  input  logic memStartA,
  input  logic memStartB,
  output logic coreDataValid,
  output mbcPkg::wordAdrT coreAdr,
  output logic coreRdInProg,
  memReqIf.core rq
);

  logic startAny;
  logic startPrev;
  logic readStart;
  logic rdActive;
  logic dvSample;
  mbcPkg::wordMaskT remMask;
  mbcPkg::wordMaskT remNext;
  logic [mbcPkg::DataValidDelay-1:0] dvPipe;

  // Finds the first set word at or above the given address, wrapping.
  function automatic mbcPkg::wordAdrT firstWord(input mbcPkg::wordMaskT mask,
                                                input mbcPkg::wordAdrT from);
    mbcPkg::wordAdrT idx;
    mbcPkg::wordAdrT pick;
    logic found;
    pick = from;
    found = 1'b0;
    for (int i = 0; i < mbcPkg::WordCount; i++) begin
      idx = from + mbcPkg::wordAdrT'(i);
      if (!found && mask[idx]) begin
        pick = idx;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  assign startAny = memStartA || memStartB;
  assign readStart = startAny && !startPrev && rq.rdRq;
  assign coreRdInProg = rdActive || readStart;

  assign dvSample = rdActive &&
                    (((memDataValidA || nxmDataValid) && aChangeComing) ||
                     ((memDataValidB || nxmDataValid) && bChangeComing));

  assign coreDataValid = dvPipe[mbcPkg::DataValidDelay-1];
  assign remNext = remMask & ~(mbcPkg::wordMaskT'(1) << coreAdr);

  always_ff @(posedge clk) begin
    if (rst) begin
      startPrev <= 1'b0;
      rdActive <= 1'b0;
      dvPipe <= '0;
    end else begin
      startPrev <= startAny;
      dvPipe <= {dvPipe[mbcPkg::DataValidDelay-2:0], dvSample};
      if (readStart) begin
        rdActive <= 1'b1;
      end else if (coreDataValid && remNext == '0) begin
        rdActive <= 1'b0;
      end
    end
  end

  // Each word handed to the core is struck from the mask.
  always_ff @(posedge clk) begin
    if (readStart) begin
      remMask <= rq.rqMask;
      coreAdr <= firstWord(rq.rqMask, rq.startAdr);
    end else if (coreDataValid) begin
      remMask <= remNext;
      coreAdr <= firstWord(remNext, coreAdr + mbcPkg::wordAdrT'(1));
    end
  end

  dataValidInRead: assert property (
    @(posedge clk) disable iff (rst)
    coreDataValid |-> rdActive
  ) else $error("Core data valid outside a core read");

endmodule

`default_nettype wire

/* hw/mbcCore.sv */
// Memory bus control top level
`default_nettype none

module mbcCore (
  input  logic clk,
  input  logic rst,
  input  logic reqValid,
  output logic reqReady,
  input  mbcPkg::wordMaskT reqWords,
  input  logic reqRead,
  input  logic reqWrite,
  input  mbcPkg::wordAdrT reqAdr,
  input  logic reqAdrPar,
  input  logic forceBadPar,
  output logic memStartA,
  output logic memStartB,
  output mbcPkg::wordMaskT memRq,
  output logic memRdRq,
  output logic memWrRq,
  output logic memAdrPar,
  output logic phaseA,
  input  logic memAcknA,
  input  logic memAcknB,
  input  logic nxmAckn,
  input  logic memDataValidA,
  input  logic memDataValidB,
  input  logic nxmDataValid,
  output logic coreDataValid,
  output mbcPkg::wordAdrT coreAdr,
  output logic coreRdInProg
);

  logic aChangeComing;
  logic bChangeComing;
  logic startDone;

  memReqIf rqBus ();

  assign memRq = rqBus.rqMask;
  assign memRdRq = rqBus.rdRq;
  assign memWrRq = rqBus.wrRq;

  phaseGen phaseGen0 (
    .clk(clk),
    .rst(rst),
    .aChangeComing(aChangeComing),
    .bChangeComing(bChangeComing),
    .phaseA(phaseA)
  );

  requestHold requestHold0 (
    .clk(clk),
    .rst(rst),
    .reqValid(reqValid),
    .reqReady(reqReady),
    .reqWords(reqWords),
    .reqRead(reqRead),
    .reqWrite(reqWrite),
    .reqAdr(reqAdr),
    .reqAdrPar(reqAdrPar),
    .forceBadPar(forceBadPar),
    .startDone(startDone),
    .memAdrPar(memAdrPar),
    .rq(rqBus.hold)
  );

  memStartCtl memStartCtl0 (
    .clk(clk),
    .rst(rst),
    .aChangeComing(aChangeComing),
    .bChangeComing(bChangeComing),
    .memAcknA(memAcknA),
    .memAcknB(memAcknB),
    .nxmAckn(nxmAckn),
    .memStartA(memStartA),
    .memStartB(memStartB),
    .startDone(startDone),
    .rq(rqBus.start)
  );

  coreReadSeq coreReadSeq0 (
    .clk(clk),
    .rst(rst),
    .aChangeComing(aChangeComing),
    .bChangeComing(bChangeComing),
    .memDataValidA(memDataValidA),
    .memDataValidB(memDataValidB),
    .nxmDataValid(nxmDataValid),
    .memStartA(memStartA),
    .memStartB(memStartB),
    .coreDataValid(coreDataValid),
    .coreAdr(coreAdr),
    .coreRdInProg(coreRdInProg),
    .rq(rqBus.core)
  );

endmodule

`default_nettype wire

/* testbench/mbcTb.sv */
// Memory bus control testbench
`default_nettype none

module mbcTb;

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct {
    string name;
    mbcPkg::wordMaskT words;
    logic read;
    mbcPkg::wordAdrT adr;
    logic adrPar;
    logic badPar;
    logic nxm;
  } reqEntryT;

  localparam int EntryCount = 8;
  localparam int SlotWait = 2 * mbcPkg::PhaseLength;

  logic clk = 1'b0;
  logic rst;
  logic reqValid, reqReady, reqRead, reqWrite, reqAdrPar, forceBadPar;
  mbcPkg::wordMaskT reqWords, memRq;
  mbcPkg::wordAdrT reqAdr, coreAdr;
  logic memStartA, memStartB, memRdRq, memWrRq, memAdrPar, phaseA;
  logic memAcknA, memAcknB, nxmAckn, memDataValidA, memDataValidB, nxmDataValid;
  logic coreDataValid, coreRdInProg;

  reqEntryT reqTable[EntryCount];
  reqEntryT cur;
  string testName;
  mbcPkg::wordAdrT wordOrder[$];
  mbcPkg::wordAdrT adrExpect[$];
  int dueQ[$];
  int cycleNo;
  logic lastPhaseA;
  logic expectRead;
  logic startInB;

  mbcCore dut0 (
    .clk(clk), .rst(rst),
    .reqValid(reqValid), .reqReady(reqReady), .reqWords(reqWords),
    .reqRead(reqRead), .reqWrite(reqWrite), .reqAdr(reqAdr),
    .reqAdrPar(reqAdrPar), .forceBadPar(forceBadPar),
    .memStartA(memStartA), .memStartB(memStartB), .memRq(memRq),
    .memRdRq(memRdRq), .memWrRq(memWrRq), .memAdrPar(memAdrPar), .phaseA(phaseA),
    .memAcknA(memAcknA), .memAcknB(memAcknB), .nxmAckn(nxmAckn),
    .memDataValidA(memDataValidA), .memDataValidB(memDataValidB),
    .nxmDataValid(nxmDataValid),
    .coreDataValid(coreDataValid), .coreAdr(coreAdr), .coreRdInProg(coreRdInProg)
  );

  always #10 clk = ~clk;

  task automatic checkValue(string what, int expected, int actual);
    if (expected != actual) begin
      $display("ERR %s %s: expected %0d, actual %0d", testName, what, expected, actual);
      $display("Verification failed");
      $fatal(1, "Stopped at the first mismatch.");
    end
  endtask

  task automatic reportTimeout(string what);
    $display("Test %s timed out while waiting for %s.", testName, what);
    $display("Verification failed");
    $fatal(1, "Stopped on a timeout.");
  endtask

  // Parity over the held parity bit, both flags, the mask, the address and the test bit.
  function automatic logic expectedParity(reqEntryT e);
    return e.adrPar ^ e.read ^ !e.read ^ (^e.words) ^ (^e.adr) ^ e.badPar;
  endfunction

  // Requested words in the order the core sees them, upward from adr with wrap.
  task automatic buildWordOrder(reqEntryT e);
    mbcPkg::wordAdrT a;
    wordOrder.delete();
    for (int i = 0; i < mbcPkg::WordCount; i++) begin
      a = e.adr + mbcPkg::wordAdrT'(i);
      if (e.words[a]) wordOrder.push_back(a);
    end
  endtask

  // Advances to the next falling edge and checks what must hold in every cycle.
  task automatic stepCycle();
    logic dvDue;
    lastPhaseA = phaseA;
    @(negedge clk);
    cycleNo++;
    checkValue("memStartA and memStartB together", 0, int'(memStartA && memStartB));
    dvDue = (dueQ.size() != 0) && (dueQ[0] == cycleNo);
    checkValue("coreDataValid", int'(dvDue), int'(coreDataValid));
    if (dvDue) begin
      void'(dueQ.pop_front());
      checkValue("coreAdr", int'(adrExpect.pop_front()), int'(coreAdr));
    end
    if (!expectRead) checkValue("coreRdInProg", 0, int'(coreRdInProg));
    if (memStartA || memStartB) begin
      checkValue("memRq", int'(cur.words), int'(memRq));
      checkValue("memRdRq", int'(cur.read), int'(memRdRq));
      checkValue("memWrRq", int'(!cur.read), int'(memWrRq));
      checkValue("memAdrPar", int'(expectedParity(cur)), int'(memAdrPar));
    end
  endtask

  // The memory answers in the slot of its start, or as a missing memory.
  task automatic driveWord(logic level);
    if (cur.nxm) begin
      nxmAckn = level;
      nxmDataValid = level && cur.read;
    end else if (startInB) begin
      memAcknB = level;
      memDataValidB = level && cur.read;
    end else begin
      memAcknA = level;
      memDataValidA = level && cur.read;
    end
  endtask

  task automatic runRequest(int idx);
    int waited;
    int lastAckCycle;
    logic ackPhase;
    cur = reqTable[idx];
    testName = cur.name;
    buildWordOrder(cur);
    expectRead = cur.read;
    if (cur.read) adrExpect = wordOrder;
    else adrExpect.delete();
    checkValue("reqReady before request", 1, int'(reqReady));
    reqValid = 1'b1;
    reqWords = cur.words;
    reqRead = cur.read;
    reqWrite = !cur.read;
    reqAdr = cur.adr;
    reqAdrPar = cur.adrPar;
    forceBadPar = cur.badPar;
    stepCycle();
    reqValid = 1'b0;
    checkValue("reqReady while held", 0, int'(reqReady));
    waited = 0;
    while (!(memStartA || memStartB)) begin
      if (waited == SlotWait) reportTimeout("a memory start");
      stepCycle();
      waited++;
    end
    startInB = memStartB;
    // A start in slot A acknowledges at the A change pulse, which ends a low phaseA slot.
    ackPhase = memStartB;
    checkValue("phaseA at start", int'(memStartA), int'(phaseA));
    checkValue("coreRdInProg at start", int'(cur.read), int'(coreRdInProg));
    for (int k = 0; k < wordOrder.size(); k++) begin
      waited = 0;
      while (!(phaseA == ackPhase && phaseA != lastPhaseA)) begin
        if (waited == SlotWait) reportTimeout("the acknowledge slot");
        stepCycle();
        waited++;
      end
      checkValue("start held", 1, int'(startInB ? memStartB : memStartA));
      driveWord(1'b1);
      stepCycle();
      if (cur.read) dueQ.push_back(cycleNo + mbcPkg::DataValidDelay);
      lastAckCycle = cycleNo;
      stepCycle();
      driveWord(1'b0);
    end
    checkValue("memStartA after last ack", 0, int'(memStartA));
    checkValue("memStartB after last ack", 0, int'(memStartB));
    waited = 0;
    while (!reqReady) begin
      if (waited == SlotWait) reportTimeout("reqReady");
      stepCycle();
      waited++;
    end
    checkValue("reqReady delay after last ack", 2, cycleNo - lastAckCycle);
    waited = 0;
    while (dueQ.size() != 0) begin
      if (waited == SlotWait) reportTimeout("core data valid");
      stepCycle();
      waited++;
    end
    expectRead = 1'b0;
    stepCycle();
  endtask

  initial begin
    int gap;
    void'($urandom(84));
    reqTable[0] = '{"readOne", 4'b0001, 1'b1, 2'd0, 1'b0, 1'b0, 1'b0};
    reqTable[1] = '{"writeAll", 4'b1111, 1'b0, 2'd2, 1'b1, 1'b0, 1'b0};
    reqTable[2] = '{"readWrap", 4'b1011, 1'b1, 2'd2, 1'b0, 1'b0, 1'b0};
    reqTable[3] = '{"readBadPar", 4'b0110, 1'b1, 2'd1, 1'b1, 1'b1, 1'b0};
    reqTable[4] = '{"writeNxm", 4'b0101, 1'b0, 2'd3, 1'b0, 1'b0, 1'b1};
    reqTable[5] = '{"readNxm", 4'b1100, 1'b1, 2'd0, 1'b0, 1'b0, 1'b1};
    reqTable[6] = '{"writeBadPar", 4'b0010, 1'b0, 2'd1, 1'b0, 1'b1, 1'b0};
    reqTable[7] = '{"readAll", 4'b1111, 1'b1, 2'd3, 1'b1, 1'b0, 1'b0};
    rst = 1'b1;
    reqValid = 1'b0;
    reqWords = '0;
    reqRead = 1'b0;
    reqWrite = 1'b0;
    reqAdr = '0;
    reqAdrPar = 1'b0;
    forceBadPar = 1'b0;
    memAcknA = 1'b0;
    memAcknB = 1'b0;
    nxmAckn = 1'b0;
    memDataValidA = 1'b0;
    memDataValidB = 1'b0;
    nxmDataValid = 1'b0;
    cycleNo = 0;
    lastPhaseA = 1'b0;
    expectRead = 1'b0;
    startInB = 1'b0;
    testName = "reset";
    repeat (10) @(negedge clk);
    rst = 1'b0;
    checkValue("memStartA", 0, int'(memStartA));
    checkValue("memStartB", 0, int'(memStartB));
    checkValue("coreDataValid", 0, int'(coreDataValid));
    checkValue("coreRdInProg", 0, int'(coreRdInProg));
    checkValue("reqReady", 1, int'(reqReady));
    for (int i = 0; i < EntryCount; i++) begin
      gap = int'($urandom % 4);
      repeat (gap) stepCycle();
      runRequest(i);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* mbcCore.f */
hw/mbcPkg.sv
hw/memReqIf.sv
hw/phaseGen.sv
hw/requestHold.sv
hw/memStartCtl.sv
hw/coreReadSeq.sv
hw/mbcCore.sv
testbench/mbcTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mbcTb -f mbcCore.f -o mbcSim

./obj_dir/mbcSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
if ! grep -q "Verification passed" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
